// File: tb.f
hartPkg.sv
fetchUnit.sv
instrDecoder.sv
regFile.sv
execUnit.sv
hazardUnit.sv
trapUnit.sv
hart.sv
hartChecker.sv
hartTb.sv

// File: run.sh
#!/bin/sh
# build and run the hart testbench with Verilator, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module hartTb -f tb.f -o hartSim \
  && ./obj_dir/hartSim > sim.log 2>&1 \
  || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

// File: hartTb.sv
// testbench for the hart with program ROM, data RAM, stall pattern and watchdog
`timescale 1ns/1ps

module hartTb import hartPkg::*; ();

  localparam int clkPeriod = 100;
  // per-cycle ready mask, random low cycles are added on top
  localparam logic [15:0] readyPattern = 16'b1110_1101_1111_0110;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] word;
  } progEntryT;

  logic        clk = 1'b0;
  logic        rstN;
  logic [31:0] imemAddr;
  logic [31:0] imemData;
  logic [31:0] dmemAddr;
  logic [31:0] dmemWData;
  logic        dmemRead;
  logic        dmemWrite;
  logic [31:0] dmemRData;
  logic        dmemReady = 1'b1;
  retireT      retire;
  logic        trapped;
  logic [31:0] mepc;
  causeT       mcause;

  logic [31:0] rom [128];
  logic [31:0] ram [64];
  progEntryT   prog [$];
  logic [3:0]  patIdx = 4'd0;
  int          entryCount;
  int          checks;
  int          errors;
  logic        done;

  always #(clkPeriod / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // instruction encoding
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] rTypeWord(input logic [6:0] funct7, input logic [2:0] funct3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] addiWord(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lwWord(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] swWord(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // offset bit 0 is dropped by the format
  function automatic logic [31:0] branchWord(input logic [2:0] funct3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jalWord(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic placeWord(input logic [31:0] pc, input logic [31:0] word);
    prog.push_back('{pc: pc, word: word});
  endtask

  ////////////////////////////////////////////////////////////
  // memory models
  ////////////////////////////////////////////////////////////

  initial begin
    // unused words carry their index and an unsupported opcode
    for (int i = 0; i < 128; i++) begin
      rom[7'(i)] = {25'(i), 7'h7f};
    end
    for (int i = 0; i < 64; i++) begin
      ram[6'(i)] = 32'hc0de_0000 ^ 32'(i);
    end
    placeWord(32'h00, addiWord(5'd1, 5'd0, 12'd5));
    placeWord(32'h04, addiWord(5'd2, 5'd1, 12'd7));
    placeWord(32'h08, rTypeWord(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    placeWord(32'h0c, rTypeWord(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
    placeWord(32'h10, rTypeWord(7'h00, 3'b100, 5'd5, 5'd3, 5'd2));
    placeWord(32'h14, rTypeWord(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
    placeWord(32'h18, rTypeWord(7'h00, 3'b111, 5'd7, 5'd6, 5'd5));
    placeWord(32'h1c, addiWord(5'd9, 5'd0, 12'hffd));
    placeWord(32'h20, rTypeWord(7'h00, 3'b010, 5'd8, 5'd9, 5'd1));
    placeWord(32'h24, swWord(5'd3, 5'd0, 12'd8));
    placeWord(32'h28, swWord(5'd5, 5'd2, 12'd12));
    placeWord(32'h2c, lwWord(5'd10, 5'd0, 12'd8));
    placeWord(32'h30, lwWord(5'd11, 5'd2, 12'd12));
    placeWord(32'h34, rTypeWord(7'h00, 3'b000, 5'd12, 5'd10, 5'd11));
    // branch section, the addi words in between must never retire
    placeWord(32'h38, branchWord(3'b000, 5'd4, 5'd2, 13'd8));
    placeWord(32'h3c, addiWord(5'd13, 5'd0, 12'd99));
    placeWord(32'h40, branchWord(3'b001, 5'd4, 5'd2, 13'd8));
    placeWord(32'h44, branchWord(3'b001, 5'd1, 5'd2, 13'd8));
    placeWord(32'h48, addiWord(5'd13, 5'd0, 12'd98));
    placeWord(32'h4c, jalWord(5'd14, 21'd8));
    placeWord(32'h50, addiWord(5'd13, 5'd0, 12'd97));
    placeWord(32'h54, branchWord(3'b000, 5'd1, 5'd2, 13'd8));
    // ecall is outside the subset
    placeWord(32'h58, 32'h0000_0073);
    // trap handler ends in a jump to itself
    placeWord(32'h100, addiWord(5'd15, 5'd0, 12'h055));
    placeWord(32'h104, swWord(5'd15, 5'd0, 12'd0));
    placeWord(32'h108, jalWord(5'd0, 21'd0));
    foreach (prog[k]) begin
      rom[prog[k].pc[8:2]] = prog[k].word;
    end
  end

  assign imemData  = rom[imemAddr[8:2]];
  // read data only shows up while a load strobe meets dmemReady
  assign dmemRData = (dmemRead && dmemReady) ? ram[dmemAddr[7:2]] : 32'hdead_beef;

  always @(posedge clk) begin
    if (dmemWrite && dmemReady) begin
      ram[dmemAddr[7:2]] <= dmemWData;
    end
  end

  // data wait pattern, changed away from the rising edge
  always @(negedge clk) begin
    dmemReady = readyPattern[patIdx] && ($urandom_range(3) != 0);
    patIdx    = patIdx + 4'd1;
  end

  ////////////////////////////////////////////////////////////
  // DUT and checker
  ////////////////////////////////////////////////////////////

  hart #(.ResetVector(32'h0), .TrapVector(32'h100)) uut (
    .clk(clk),
    .rstN(rstN),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .dmemAddr(dmemAddr),
    .dmemWData(dmemWData),
    .dmemRead(dmemRead),
    .dmemWrite(dmemWrite),
    .dmemRData(dmemRData),
    .dmemReady(dmemReady),
    .retire(retire),
    .trapped(trapped),
    .mepc(mepc),
    .mcause(mcause)
  );

  hartChecker chk (
    .clk(clk),
    .rstN(rstN),
    .retire(retire),
    .dmemAddr(dmemAddr),
    .dmemWData(dmemWData),
    .dmemWrite(dmemWrite),
    .dmemReady(dmemReady),
    .trapped(trapped),
    .mepc(mepc),
    .mcause(mcause),
    .entryCount(entryCount),
    .checks(checks),
    .errors(errors),
    .done(done)
  );

  ////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h6fb4));
    rstN = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    wait (done);
    @(negedge clk);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // allows 20 cycles for every expected event
  initial begin
    @(posedge rstN);
    repeat (entryCount * 20) @(posedge clk);
    $display("timeout waiting for retire");
    $display("checks %0d errors %0d", checks, errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: hartChecker.sv
// hart checker comparing retire, store and trap events with hand-computed expectations
`timescale 1ns/1ps

module hartChecker import hartPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  retireT      retire,
  input  logic [31:0] dmemAddr,
  input  logic [31:0] dmemWData,
  input  logic        dmemWrite,
  input  logic        dmemReady,
  input  logic        trapped,
  input  logic [31:0] mepc,
  input  causeT       mcause,
  output int          entryCount,
  output int          checks,
  output int          errors,
  output logic        done
);

  ////////////////////////////////////////////////////////////
  // expected tables
  ////////////////////////////////////////////////////////////

  // one retired instruction, data is ignored when rd is x0
  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
  } retireExpT;

  // order counts the retires that come before the access
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    int          order;
  } storeExpT;

  typedef struct packed {
    logic [31:0] pc;
    causeT       cause;
    int          order;
  } trapExpT;

  retireExpT retExp [$];
  string     retName [$];
  storeExpT  stExp [$];
  string     stName [$];
  trapExpT   trExp [$];
  string     trName [$];

  int   retIdx = 0;
  int   stIdx = 0;
  int   trIdx = 0;
  int   checkCount = 0;
  int   errCount = 0;
  int   tableSize = 0;
  logic trapPending = 1'b0;
  logic trapOrderOk = 1'b1;
  logic allDone = 1'b0;

  assign entryCount = tableSize;
  assign checks     = checkCount;
  assign errors     = errCount;
  assign done       = allDone;

  task automatic retireEntry(input string name, input logic [31:0] pc, input logic [4:0] rd,
                             input logic [31:0] data);
    retExp.push_back('{pc: pc, rd: rd, data: data});
    retName.push_back(name);
  endtask

  task automatic storeEntry(input string name, input logic [31:0] addr,
                            input logic [31:0] data, input int order);
    stExp.push_back('{addr: addr, data: data, order: order});
    stName.push_back(name);
  endtask

  task automatic trapEntry(input string name, input logic [31:0] pc, input int order);
    trExp.push_back('{pc: pc, cause: illegalInstr, order: order});
    trName.push_back(name);
  endtask

  // values follow the RV32I rules for the program in the testbench
  initial begin
    retireEntry("addi x1", 32'h00, 5'd1, 32'd5);
    retireEntry("addi x2 fwd", 32'h04, 5'd2, 32'd12);
    retireEntry("add x3", 32'h08, 5'd3, 32'd17);
    retireEntry("sub x4", 32'h0c, 5'd4, 32'd12);
    retireEntry("xor x5", 32'h10, 5'd5, 32'd29);
    retireEntry("or x6", 32'h14, 5'd6, 32'd13);
    retireEntry("and x7", 32'h18, 5'd7, 32'd13);
    retireEntry("addi x9 neg", 32'h1c, 5'd9, 32'hffff_fffd);
    retireEntry("slt x8", 32'h20, 5'd8, 32'd1);
    retireEntry("sw retire 24", 32'h24, 5'd0, 32'd0);
    retireEntry("sw retire 28", 32'h28, 5'd0, 32'd0);
    retireEntry("lw x10", 32'h2c, 5'd10, 32'd17);
    retireEntry("lw x11", 32'h30, 5'd11, 32'd29);
    retireEntry("add x12 after load", 32'h34, 5'd12, 32'd46);
    retireEntry("beq taken", 32'h38, 5'd0, 32'd0);
    retireEntry("bne not taken", 32'h40, 5'd0, 32'd0);
    retireEntry("bne taken", 32'h44, 5'd0, 32'd0);
    retireEntry("jal x14", 32'h4c, 5'd14, 32'h50);
    retireEntry("beq not taken", 32'h54, 5'd0, 32'd0);
    retireEntry("trap vector addi", 32'h100, 5'd15, 32'h55);
    retireEntry("sw retire 104", 32'h104, 5'd0, 32'd0);
    retireEntry("jal loop", 32'h108, 5'd0, 32'd0);
    storeEntry("sw x3 to 8", 32'h08, 32'd17, 9);
    storeEntry("sw x5 to 18", 32'h18, 32'd29, 10);
    storeEntry("sw x15 to 0", 32'h00, 32'h55, 20);
    trapEntry("illegal at 58", 32'h58, 19);
    tableSize = retExp.size() + stExp.size() + trExp.size();
  end

  ////////////////////////////////////////////////////////////
  // comparisons
  ////////////////////////////////////////////////////////////

  task automatic checkRetire();
    retireExpT e;
    e = retExp[retIdx];
    checkCount++;
    if (retire.pc !== e.pc || retire.rd !== e.rd ||
        (e.rd != 5'd0 && retire.data !== e.data)) begin
      errCount++;
      $display("Fail %s: expected pc %h rd %0d data %h, actual pc %h rd %0d data %h",
               retName[retIdx], e.pc, e.rd, e.data, retire.pc, retire.rd, retire.data);
    end else begin
      $display("ok   %s", retName[retIdx]);
    end
    retIdx++;
  endtask

  task automatic checkStore();
    storeExpT e;
    if (stIdx >= stExp.size()) begin
      errCount++;
      $display("unexpected store of %h to address %h", dmemWData, dmemAddr);
    end else begin
      e = stExp[stIdx];
      checkCount++;
      if (retIdx != e.order) begin
        errCount++;
        $display("%s happened after %0d retires instead of %0d", stName[stIdx], retIdx,
                 e.order);
      end else if (dmemAddr !== e.addr || dmemWData !== e.data) begin
        errCount++;
        $display("Fail %s: expected addr %h data %h, actual addr %h data %h",
                 stName[stIdx], e.addr, e.data, dmemAddr, dmemWData);
      end else begin
        $display("ok   %s", stName[stIdx]);
      end
      stIdx++;
    end
  endtask

  // mepc and mcause are only valid one edge after the pulse
  task automatic noteTrap();
    if (trapPending || trIdx >= trExp.size()) begin
      errCount++;
      $display("unexpected trap after %0d retires", retIdx);
    end else begin
      trapPending = 1'b1;
      trapOrderOk = (retIdx == trExp[trIdx].order);
    end
  endtask

  task automatic checkTrap();
    trapExpT e;
    e = trExp[trIdx];
    checkCount++;
    if (!trapOrderOk) begin
      errCount++;
      $display("%s was taken out of order, not after %0d retires", trName[trIdx], e.order);
    end else if (mepc !== e.pc || mcause !== e.cause) begin
      errCount++;
      $display("Fail %s: expected mepc %h mcause %0d, actual mepc %h mcause %0d",
               trName[trIdx], e.pc, e.cause, mepc, mcause);
    end else begin
      $display("ok   %s", trName[trIdx]);
    end
    trapPending = 1'b0;
    trIdx++;
  endtask

  // pre-edge values, so retire of the older instruction is counted before a store or trap
  always @(posedge clk) begin
    if (rstN) begin
      if (trapPending) begin
        checkTrap();
      end
      if (retire.valid && retIdx < retExp.size()) begin
        checkRetire();
      end
      if (trapped) begin
        noteTrap();
      end
      if (dmemWrite && dmemReady) begin
        checkStore();
      end
      allDone = (retIdx == retExp.size()) && (stIdx == stExp.size()) &&
                (trIdx == trExp.size());
    end
  end

endmodule

// File: hart.sv
// top level of the three-stage RV32I hart joining fetch, execute, hazard and trap units
`timescale 1ns/1ps

module hart import hartPkg::*; #(
  parameter logic [xlen-1:0] ResetVector = '0,
  parameter logic [xlen-1:0] TrapVector  = 32'h100
) (
  input  logic            clk,
  input  logic            rstN,
  // instruction port
  output logic [xlen-1:0] imemAddr,
  input  logic [31:0]     imemData,
  // data port
  output logic [xlen-1:0] dmemAddr,
  output logic [xlen-1:0] dmemWData,
  output logic            dmemRead,
  output logic            dmemWrite,
  input  logic [xlen-1:0] dmemRData,
  input  logic            dmemReady,
  // retire and trap status
  output retireT          retire,
  output logic            trapped,
  output logic [xlen-1:0] mepc,
  output causeT           mcause
);

  // F to E
  instrT           instrE;
  logic [xlen-1:0] pcE;
  logic            validE;

  // execute results back to fetch and control
  logic            redirectE;
  logic [xlen-1:0] targetE;
  logic            illegalE;
  logic            memWaitE;

  // trap steering
  logic            trapTaken;
  logic [xlen-1:0] trapTarget;

  // global control
  logic            stallF;
  logic            stallE;
  logic            flushE;

  // pc, next-pc choice and instruction register
  fetchUnit #(.ResetVector(ResetVector)) ifu (.*);

  // decode, registers, ALU, data access and writeback
  execUnit ieu (.*);

  // stall and flush control
  hazardUnit hzu (.*);

  // illegal instruction handling
  trapUnit #(.TrapVector(TrapVector)) trap (.*);

endmodule

// File: trapUnit.sv
// trap unit recording mepc and mcause and steering fetch to the trap vector
`timescale 1ns/1ps

module trapUnit import hartPkg::*; #(
  parameter logic [xlen-1:0] TrapVector = 32'h100
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            illegalE,
  input  logic [xlen-1:0] pcE,
  output logic            trapTaken,
  output logic            trapped,
  output logic [xlen-1:0] trapTarget,
  output logic [xlen-1:0] mepc,
  output causeT           mcause
);

  // trap is taken in the same E cycle the illegal word is seen
  assign trapTaken  = illegalE;
  assign trapped    = trapTaken;
  assign trapTarget = TrapVector;

  ////////////////////////////////////////////////////////////
  // trap registers
  ////////////////////////////////////////////////////////////

  // loaded on the edge that ends the trapping cycle
  always_ff @(posedge clk) begin
    if (trapTaken) begin
      mepc   <= pcE;
      mcause <= illegalInstr;
    end
  end

  // the flush behind a trap means the next E cycle is empty
  trapOnce: assert property (@(posedge clk) disable iff (!rstN) trapTaken |=> !trapTaken)
    else $error("trap taken on two consecutive cycles");

endmodule

// File: hazardUnit.sv
// hazard unit deciding the global stall and the flush of the F to E register
`timescale 1ns/1ps

module hazardUnit (
  input  logic memWaitE,
  input  logic redirectE,
  input  logic trapTaken,
  output logic stallF,
  output logic stallE,
  output logic flushE
);

  ////////////////////////////////////////////////////////////
  // stalls
  ////////////////////////////////////////////////////////////

  // a load or store waiting on memory freezes fetch and execute
  assign stallF = memWaitE;
  // execute keeps its instruction and sends a bubble to writeback
  assign stallE = memWaitE;

  ////////////////////////////////////////////////////////////
  // flush
  ////////////////////////////////////////////////////////////

  // taken branch, jal or trap kills the word behind it
  // a stalled cycle keeps everything in place instead
  assign flushE = (redirectE || trapTaken) && !memWaitE;

endmodule

// File: execUnit.sv
// execute stage with forwarding, ALU, branch resolution, data access and writeback register
`timescale 1ns/1ps

module execUnit import hartPkg::*; (
  input  logic            clk,
  input  logic            rstN,
  input  instrT           instrE,
  input  logic [xlen-1:0] pcE,
  input  logic            validE,
  input  logic            stallE,
  output logic [xlen-1:0] dmemAddr,
  output logic [xlen-1:0] dmemWData,
  output logic            dmemRead,
  output logic            dmemWrite,
  input  logic [xlen-1:0] dmemRData,
  input  logic            dmemReady,
  output logic            redirectE,
  output logic [xlen-1:0] targetE,
  output logic            illegalE,
  output logic            memWaitE,
  output retireT          retire
);

  ctrlT            ctrlE;
  logic [xlen-1:0] immE;
  logic [4:0]      rs1E;
  logic [4:0]      rs2E;
  logic [4:0]      rdE;
  logic [xlen-1:0] rd1E;
  logic [xlen-1:0] rd2E;
  logic [xlen-1:0] opAE;
  logic [xlen-1:0] opBE;
  logic [xlen-1:0] srcBE;
  logic [xlen-1:0] aluResultE;
  logic [xlen-1:0] resultE;
  logic            equalE;
  logic            takenE;
  wbT              wbW;

  assign rs1E = instrE.rType.rs1;
  assign rs2E = instrE.rType.rs2;
  assign rdE  = instrE.rType.rd;

  instrDecoder dec (.instr(instrE), .ctrl(ctrlE), .imm(immE));

  // W stage writes through the same payload that goes out on retire
  regFile rf (
    .clk(clk),
    .rs1(rs1E),
    .rs2(rs2E),
    .rd1(rd1E),
    .rd2(rd2E),
    .we (wbW.valid),
    .wa (wbW.rd),
    .wd (wbW.data)
  );

  ////////////////////////////////////////////////////////////
  // operands and ALU
  ////////////////////////////////////////////////////////////

  // W result is one edge short of the register file, take it directly
  assign opAE  = (wbW.valid && wbW.rd != 5'd0 && wbW.rd == rs1E) ? wbW.data : rd1E;
  assign opBE  = (wbW.valid && wbW.rd != 5'd0 && wbW.rd == rs2E) ? wbW.data : rd2E;
  assign srcBE = ctrlE.aluSrcImm ? immE : opBE;

  always_comb begin
    case (ctrlE.aluOp)
      aluAdd:  aluResultE = opAE + srcBE;
      aluSub:  aluResultE = opAE - srcBE;
      aluAnd:  aluResultE = opAE & srcBE;
      aluOr:   aluResultE = opAE | srcBE;
      aluXor:  aluResultE = opAE ^ srcBE;
      aluSlt:  aluResultE = {{(xlen-1){1'b0}}, $signed(opAE) < $signed(srcBE)};
      default: aluResultE = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // branch, jump and trap report
  ////////////////////////////////////////////////////////////

  assign equalE    = (opAE == opBE);
  assign takenE    = ctrlE.branch && (ctrlE.branchNe ? !equalE : equalE);
  assign redirectE = validE && (takenE || ctrlE.jump);
  assign targetE   = pcE + immE;
  assign illegalE  = validE && ctrlE.illegal;

  ////////////////////////////////////////////////////////////
  // data access
  ////////////////////////////////////////////////////////////

  assign dmemAddr  = aluResultE;
  assign dmemWData = opBE;
  assign dmemRead  = validE && ctrlE.memRead;
  assign dmemWrite = validE && ctrlE.memWrite;
  // hazard unit turns this into the stall
  assign memWaitE  = (dmemRead || dmemWrite) && !dmemReady;

  // jal links pc plus 4, loads take the memory word
  always_comb begin
    if (ctrlE.jump) begin
      resultE = pcE + xlen'(4);
    end else if (ctrlE.memRead) begin
      resultE = dmemRData;
    end else begin
      resultE = aluResultE;
    end
  end

  ////////////////////////////////////////////////////////////
  // E to W register
  ////////////////////////////////////////////////////////////

  // held instructions leave a bubble, non-writers retire with rd of x0
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbW.valid <= 1'b0;
    end else begin
      wbW.valid <= validE && !ctrlE.illegal && !stallE;
    end
    wbW.rd   <= ctrlE.regWrite ? rdE : 5'd0;
    wbW.data <= ctrlE.regWrite ? resultE : '0;
    wbW.pc   <= pcE;
  end

  assign retire = '{valid: wbW.valid, pc: wbW.pc, rd: wbW.rd, data: wbW.data};

  // decoder never asks for a load and a store at once
  strobeExcl: assert property (@(posedge clk) disable iff (!rstN) !(dmemRead && dmemWrite))
    else $error("dmemRead and dmemWrite high together");

  // an unaccepted store is presented again unchanged
  storeHeld: assert property (@(posedge clk) disable iff (!rstN)
    (dmemWrite && !dmemReady) |=> dmemWrite && $stable(dmemAddr) && $stable(dmemWData))
    else $error("store changed while waiting for dmemReady");

endmodule

// File: regFile.sv
// integer register file with two combinational reads and one clocked write
`timescale 1ns/1ps

module regFile import hartPkg::*; (
  input  logic            clk,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  output logic [xlen-1:0] rd1,
  output logic [xlen-1:0] rd2,
  input  logic            we,
  input  logic [4:0]      wa,
  input  logic [xlen-1:0] wd
);

  // x0 has no storage
  logic [xlen-1:0] regs [1:31];

  // written on the edge that ends the W cycle
  always_ff @(posedge clk) begin
    if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

  // reads of x0 return zero
  assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: instrDecoder.sv
// instruction decoder producing the control fields and sign-extended immediate
`timescale 1ns/1ps

module instrDecoder import hartPkg::*; (
  input  instrT           instr,
  output ctrlT            ctrl,
  output logic [xlen-1:0] imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // opcode and funct fields sit at the same bits in every format
  assign opcode = instr.rType.opcode;
  assign funct3 = instr.rType.funct3;
  assign funct7 = instr.rType.funct7;

  ////////////////////////////////////////////////////////////
  // immediate
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (opcode)
      opImm, opLoad: imm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
      opStore: imm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
      // branch and jump offsets are in halfwords, low bit is zero
      opBranch: imm = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
                       instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
      opJal: imm = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.imm19to12,
                    instr.jType.imm11, instr.jType.imm10to1, 1'b0};
      default: imm = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  always_comb begin
    ctrl = '0;
    ctrl.aluOp = aluAdd;
    case (opcode)
      opReg: begin
        ctrl.regWrite = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: ctrl.aluOp = aluAdd;
          {7'b0100000, 3'b000}: ctrl.aluOp = aluSub;
          {7'b0000000, 3'b111}: ctrl.aluOp = aluAnd;
          {7'b0000000, 3'b110}: ctrl.aluOp = aluOr;
          {7'b0000000, 3'b100}: ctrl.aluOp = aluXor;
          {7'b0000000, 3'b010}: ctrl.aluOp = aluSlt;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      opImm: begin
        // addi only
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.illegal   = (funct3 != 3'b000);
      end
      opLoad: begin
        // lw only, address is rs1 plus offset
        ctrl.regWrite  = 1'b1;
        ctrl.memRead   = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.illegal   = (funct3 != 3'b010);
      end
      opStore: begin
        ctrl.memWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.illegal   = (funct3 != 3'b010);
      end
      opBranch: begin
        // beq and bne compare rs1 with rs2
        ctrl.branch   = 1'b1;
        ctrl.branchNe = (funct3 == 3'b001);
        ctrl.illegal  = (funct3[2:1] != 2'b00);
      end
      opJal: begin
        ctrl.regWrite = 1'b1;
        ctrl.jump     = 1'b1;
      end
      default: ctrl.illegal = 1'b1;
    endcase
    // a trapping instruction changes no architectural state
    if (ctrl.illegal) begin
      ctrl.regWrite = 1'b0;
      ctrl.memRead  = 1'b0;
      ctrl.memWrite = 1'b0;
      ctrl.branch   = 1'b0;
      ctrl.jump     = 1'b0;
    end
  end

endmodule

// File: fetchUnit.sv
// fetch unit holding the pc, choosing the next pc and registering the word into execute
`timescale 1ns/1ps

module fetchUnit import hartPkg::*; #(
  parameter logic [xlen-1:0] ResetVector = '0
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            stallF,
  input  logic            flushE,
  input  logic            redirectE,
  input  logic [xlen-1:0] targetE,
  input  logic            trapTaken,
  input  logic [xlen-1:0] trapTarget,
  output logic [xlen-1:0] imemAddr,
  input  logic [31:0]     imemData,
  output instrT           instrE,
  output logic [xlen-1:0] pcE,
  output logic            validE
);

  logic [xlen-1:0] pcF;
  logic [xlen-1:0] pcNext;

  ////////////////////////////////////////////////////////////
  // program counter
  ////////////////////////////////////////////////////////////

  // trap wins over a branch or jump, sequential fetch last
  always_comb begin
    if (trapTaken) begin
      pcNext = trapTarget;
    end else if (redirectE) begin
      pcNext = targetE;
    end else begin
      pcNext = pcF + xlen'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcF <= ResetVector;
    end else if (!stallF) begin
      pcF <= pcNext;
    end
  end

  // instruction memory is read combinationally from the current pc
  assign imemAddr = pcF;

  ////////////////////////////////////////////////////////////
  // F to E register
  ////////////////////////////////////////////////////////////

  // a flush kills the word fetched behind a redirect or trap
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validE <= 1'b0;
    end else if (flushE) begin
      validE <= 1'b0;
    end else if (!stallF) begin
      validE <= 1'b1;
    end
  end

  // word and pc hold together with the valid bit during a data wait
  always_ff @(posedge clk) begin
    if (!stallF) begin
      instrE <= imemData;
      pcE    <= pcF;
    end
  end

  // branch, jump and trap targets all have to land on a word
  pcAligned: assert property (@(posedge clk) disable iff (!rstN) pcF[1:0] == 2'b00)
    else $error("fetch pc %h is not word aligned", pcF);

endmodule

// File: hartPkg.sv
// hart package with instruction views, control fields, trap causes and stage payloads
package hartPkg;

  ////////////////////////////////////////////////////////////
  // widths and opcodes
  ////////////////////////////////////////////////////////////

  // register and address width of the integer core
  localparam int xlen = 32;

  // major opcodes of the supported subset
  localparam logic [6:0] opReg    = 7'b0110011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;

  ////////////////////////////////////////////////////////////
  // instruction word views
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeT;

  // store immediate split around rs2 and rs1
  typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    logic [6:0] opcode;
  } sTypeT;

  // branch offset is scrambled, bit 0 is implied zero
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;
    logic [6:0] opcode;
  } bTypeT;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10to1;
    logic       imm11;
    logic [7:0] imm19to12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jTypeT;

  // one fetched word, read through whichever format the opcode selects
  typedef union packed {
    rTypeT rType;
    iTypeT iType;
    sTypeT sType;
    bTypeT bType;
    jTypeT jType;
  } instrT;

  ////////////////////////////////////////////////////////////
  // control, causes and stage payloads
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt
  } aluOpT;

  typedef struct packed {
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  branch;
    logic  branchNe;
    logic  jump;
    logic  aluSrcImm;
    aluOpT aluOp;
    logic  illegal;
  } ctrlT;

  // only illegal instruction can trap in this core
  typedef enum logic [3:0] {
    illegalInstr = 4'd2
  } causeT;

  // execute to writeback register
  typedef struct packed {
    logic            valid;
    logic [4:0]      rd;
    logic [xlen-1:0] data;
    logic [xlen-1:0] pc;
  } wbT;

  // retired instruction as seen outside the hart
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [4:0]      rd;
    logic [xlen-1:0] data;
  } retireT;

endpackage
